// File: wtc_pkg.sv
/*
 * cache geometry constants and the load, store and memory port structs
 */
`default_nettype none

package wtc_pkg;

  localparam int ADDR_W         = 16;
  localparam int WORD_W         = 32;
  localparam int BE_W           = WORD_W / 8;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W         = WORDS_PER_LINE * WORD_W;
  localparam int NUM_SETS       = 16;
  localparam int IDX_W          = $clog2(NUM_SETS);
  localparam int OFF_W          = $clog2(WORDS_PER_LINE);
  // address split from the top down into tag, index, word offset and 2 byte bits
  localparam int TAG_W          = ADDR_W - IDX_W - OFF_W - 2;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } ld_req_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;
  } ld_resp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] data;
    logic [BE_W-1:0]   be;
  } st_req_t;

  // reads are always full line reads at the line address
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } mem_req_t;

  typedef struct packed {
    logic [WORDS_PER_LINE-1:0][WORD_W-1:0] data;
  } mem_rtrn_t;

endpackage

`default_nettype wire

// File: wtc_flush_cnt.sv
/*
 * set index counter that walks the sets during a flush and flags the last one
 */
`timescale 1ns/1ps
`default_nettype none

module wtc_flush_cnt (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     cnt_start_i,
  input  logic                     cnt_step_i,
  output logic [wtc_pkg::IDX_W-1:0] cnt_idx_o,
  output logic                     cnt_last_o
);

  logic [wtc_pkg::IDX_W-1:0] idx_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      idx_q <= '0;
    end else if (cnt_start_i) begin
      idx_q <= '0;
    end else if (cnt_step_i) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  assign cnt_idx_o  = idx_q;
  // high while sitting on the final set
  assign cnt_last_o = (idx_q == wtc_pkg::IDX_W'(wtc_pkg::NUM_SETS - 1));

endmodule

`default_nettype wire

// File: wtc_mem.sv
/*
 * valid, tag and data arrays of the direct-mapped cache
 * registered lookup with hit detection, refill, store-hit merge, invalidation
 */
`timescale 1ns/1ps
`default_nettype none

module wtc_mem (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      lookup_valid_i,
  input  logic [wtc_pkg::ADDR_W-1:0] lookup_addr_i,
  output logic                      hit_o,
  output logic [wtc_pkg::WORD_W-1:0] rdata_o,
  input  logic                      refill_we_i,
  input  logic [wtc_pkg::ADDR_W-1:0] refill_addr_i,
  input  wtc_pkg::mem_rtrn_t        refill_line_i,
  input  logic                      st_we_i,
  input  wtc_pkg::st_req_t          st_req_i,
  input  logic                      inval_we_i,
  input  logic [wtc_pkg::IDX_W-1:0]  inval_idx_i
);

  localparam int OffLo = 2;
  localparam int IdxLo = OffLo + wtc_pkg::OFF_W;
  localparam int TagLo = IdxLo + wtc_pkg::IDX_W;

  logic [wtc_pkg::NUM_SETS-1:0] valid_q;
  logic [wtc_pkg::TAG_W-1:0]    tag_q  [wtc_pkg::NUM_SETS];
  logic [wtc_pkg::WORDS_PER_LINE-1:0][wtc_pkg::WORD_W-1:0] data_q [wtc_pkg::NUM_SETS];

  logic [wtc_pkg::IDX_W-1:0] lk_idx, rf_idx, st_idx;
  logic [wtc_pkg::OFF_W-1:0] lk_off, st_off;
  logic                      lk_hit, st_hit;
  logic                      hit_q;
  logic [wtc_pkg::WORD_W-1:0] rdata_q;

  assign lk_idx = lookup_addr_i[TagLo-1:IdxLo];
  assign lk_off = lookup_addr_i[IdxLo-1:OffLo];
  assign rf_idx = refill_addr_i[TagLo-1:IdxLo];
  assign st_idx = st_req_i.addr[TagLo-1:IdxLo];
  assign st_off = st_req_i.addr[IdxLo-1:OffLo];

  assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lookup_addr_i[wtc_pkg::ADDR_W-1:TagLo]);
  // store only touches the array when the line is resident
  assign st_hit = st_we_i && valid_q[st_idx] &&
                  (tag_q[st_idx] == st_req_i.addr[wtc_pkg::ADDR_W-1:TagLo]);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
      hit_q   <= 1'b0;
    end else begin
      if (inval_we_i) begin
        valid_q[inval_idx_i] <= 1'b0;
      end else if (refill_we_i) begin
        valid_q[rf_idx] <= 1'b1;
      end
      if (lookup_valid_i) begin
        hit_q <= lk_hit;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_valid_i) begin
      rdata_q <= data_q[lk_idx][lk_off];
    end
    if (refill_we_i) begin
      tag_q[rf_idx]  <= refill_addr_i[wtc_pkg::ADDR_W-1:TagLo];
      data_q[rf_idx] <= refill_line_i.data;
    end
    if (st_hit) begin
      for (int b = 0; b < wtc_pkg::BE_W; b++) begin
        if (st_req_i.be[b]) begin
          data_q[st_idx][st_off][8*b +: 8] <= st_req_i.data[8*b +: 8];
        end
      end
    end
  end

  assign hit_o   = hit_q;
  assign rdata_o = rdata_q;

  // refill and flush walk are separate FSM phases
  a_no_refill_inval: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(refill_we_i && inval_we_i));

endmodule

`default_nettype wire

// File: wtc_wbuffer.sv
/*
 * circular store FIFO feeding the write-through path
 * word address match against the pending load, empty flag
 */
`timescale 1ns/1ps
`default_nettype none

module wtc_wbuffer #(
  parameter int WbufDepth = 4
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      st_valid_i,
  input  wtc_pkg::st_req_t          st_req_i,
  output logic                      st_ready_o,
  input  logic                      flush_busy_i,
  output logic                      head_valid_o,
  output wtc_pkg::st_req_t          head_o,
  input  logic                      pop_i,
  input  logic [wtc_pkg::ADDR_W-1:0] chk_addr_i,
  output logic                      hazard_o,
  output logic                      empty_o
);

  localparam int PtrW = (WbufDepth > 1) ? $clog2(WbufDepth) : 1;

  wtc_pkg::st_req_t     fifo_q [WbufDepth];
  logic [WbufDepth-1:0] vld_q;
  logic [PtrW-1:0]      wr_ptr_q, rd_ptr_q;
  logic                 push;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] p);
    return (p == PtrW'(WbufDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty_o      = ~|vld_q;
  assign st_ready_o   = ~&vld_q && !flush_busy_i;
  assign push         = st_valid_i && st_ready_o;
  assign head_valid_o = !empty_o;
  assign head_o       = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        vld_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q        <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        vld_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q        <= ptr_inc(rd_ptr_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= st_req_i;
    end
  end

  // any pending store to the same word blocks the load
  always_comb begin
    hazard_o = 1'b0;
    for (int i = 0; i < WbufDepth; i++) begin
      if (vld_q[i] && (fifo_q[i].addr[wtc_pkg::ADDR_W-1:2] == chk_addr_i[wtc_pkg::ADDR_W-1:2])) begin
        hazard_o = 1'b1;
      end
    end
  end

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: wtc_missunit.sv
/*
 * control FSM: load lookup, hazard stall, refill and bypass loads,
 * write-through drain of the store buffer, flush walk
 */
`timescale 1ns/1ps
`default_nettype none

module wtc_missunit (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      enable_i,
  input  logic                      flush_i,
  output logic                      flush_ack_o,
  output logic                      miss_o,
  // load port
  input  logic                      ld_req_valid_i,
  input  wtc_pkg::ld_req_t          ld_req_i,
  output logic                      ld_req_ready_o,
  output logic                      ld_resp_valid_o,
  output wtc_pkg::ld_resp_t         ld_resp_o,
  // memory port
  output logic                      mem_req_valid_o,
  input  logic                      mem_req_ready_i,
  output wtc_pkg::mem_req_t         mem_req_o,
  input  logic                      mem_rtrn_valid_i,
  input  wtc_pkg::mem_rtrn_t        mem_rtrn_i,
  // cache arrays
  output logic                      lookup_valid_o,
  output logic [wtc_pkg::ADDR_W-1:0] lookup_addr_o,
  input  logic                      hit_i,
  input  logic [wtc_pkg::WORD_W-1:0] rdata_i,
  output logic                      refill_we_o,
  output logic [wtc_pkg::ADDR_W-1:0] refill_addr_o,
  output wtc_pkg::mem_rtrn_t        refill_line_o,
  output logic                      st_we_o,
  output wtc_pkg::st_req_t          st_req_o,
  output logic                      inval_we_o,
  output logic [wtc_pkg::IDX_W-1:0]  inval_idx_o,
  // write buffer
  input  logic                      wb_head_valid_i,
  input  wtc_pkg::st_req_t          wb_head_i,
  output logic                      wb_pop_o,
  output logic [wtc_pkg::ADDR_W-1:0] wb_chk_addr_o,
  input  logic                      wb_hazard_i,
  input  logic                      wb_empty_i,
  // flush counter
  output logic                      cnt_start_o,
  output logic                      cnt_step_o,
  input  logic [wtc_pkg::IDX_W-1:0]  cnt_idx_i,
  input  logic                      cnt_last_i
);

  typedef enum logic [3:0] {
    IDLE, LOOKUP, HAZARD_WAIT, REFILL_REQ, REFILL_WAIT,
    DRAIN, FLUSH_DRAIN, FLUSH_INVAL, FLUSH_ACK
  } state_e;

  localparam int LineLo = wtc_pkg::OFF_W + 2;

  state_e                     state_q, state_d;
  logic [wtc_pkg::ADDR_W-1:0] ld_addr_q;
  logic                       drain, rd_req;
  logic                       resp_valid_q, resp_valid_d;
  logic [wtc_pkg::WORD_W-1:0] resp_data_d;
  wtc_pkg::ld_resp_t          resp_q;

  ////////////////////////////////////////////////////////////////////////////
  // next state and control
  ////////////////////////////////////////////////////////////////////////////

  assign ld_req_ready_o = (state_q == IDLE) && !flush_i;

  always_comb begin
    state_d        = state_q;
    lookup_valid_o = 1'b0;
    drain          = 1'b0;
    rd_req         = 1'b0;
    resp_valid_d   = 1'b0;
    resp_data_d    = rdata_i;
    refill_we_o    = 1'b0;
    miss_o         = 1'b0;
    cnt_start_o    = 1'b0;
    cnt_step_o     = 1'b0;
    inval_we_o     = 1'b0;
    flush_ack_o    = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (flush_i) begin
          state_d = FLUSH_DRAIN;
        end else if (ld_req_valid_i) begin
          lookup_valid_o = 1'b1;
          state_d        = LOOKUP;
        end else if (wb_head_valid_i) begin
          drain = 1'b1;
          // hold the write until memory takes it
          if (!mem_req_ready_i) state_d = DRAIN;
        end
      end
      LOOKUP: begin
        if (wb_hazard_i) begin
          state_d = HAZARD_WAIT;
        end else if (enable_i && hit_i) begin
          resp_valid_d = 1'b1;
          state_d      = IDLE;
        end else begin
          miss_o  = 1'b1;
          state_d = REFILL_REQ;
        end
      end
      HAZARD_WAIT: begin
        // drain until the conflicting store is gone, then look up again
        if (!wb_hazard_i) begin
          lookup_valid_o = 1'b1;
          state_d        = LOOKUP;
        end else begin
          drain = 1'b1;
        end
      end
      REFILL_REQ: begin
        rd_req = 1'b1;
        if (mem_req_ready_i) state_d = REFILL_WAIT;
      end
      REFILL_WAIT: begin
        if (mem_rtrn_valid_i) begin
          refill_we_o  = enable_i;
          resp_valid_d = 1'b1;
          resp_data_d  = mem_rtrn_i.data[ld_addr_q[LineLo-1:2]];
          state_d      = IDLE;
        end
      end
      DRAIN: begin
        drain = 1'b1;
        if (mem_req_ready_i) state_d = IDLE;
      end
      FLUSH_DRAIN: begin
        if (!wb_empty_i) begin
          drain = 1'b1;
        end else begin
          cnt_start_o = 1'b1;
          state_d     = FLUSH_INVAL;
        end
      end
      FLUSH_INVAL: begin
        inval_we_o = 1'b1;
        cnt_step_o = 1'b1;
        if (cnt_last_i) state_d = FLUSH_ACK;
      end
      FLUSH_ACK: begin
        flush_ack_o = 1'b1;
        state_d     = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory request and array side signals
  ////////////////////////////////////////////////////////////////////////////

  assign mem_req_valid_o = drain || rd_req;
  assign wb_pop_o        = drain && mem_req_ready_i;
  // store-hit update goes with the accepted write
  assign st_we_o         = wb_pop_o;
  assign st_req_o        = wb_head_i;

  always_comb begin
    mem_req_o = '0;
    if (drain) begin
      mem_req_o.we    = 1'b1;
      mem_req_o.addr  = wb_head_i.addr;
      mem_req_o.wdata = wb_head_i.data;
      mem_req_o.be    = wb_head_i.be;
    end else begin
      mem_req_o.addr = {ld_addr_q[wtc_pkg::ADDR_W-1:LineLo], {LineLo{1'b0}}};
    end
  end

  assign lookup_addr_o = (state_q == IDLE) ? ld_req_i.addr : ld_addr_q;
  assign wb_chk_addr_o = ld_addr_q;
  assign refill_addr_o = ld_addr_q;
  assign refill_line_o = mem_rtrn_i;
  assign inval_idx_o   = cnt_idx_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= IDLE;
      resp_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      resp_valid_q <= resp_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ld_req_valid_i && ld_req_ready_o) begin
      ld_addr_q <= ld_req_i.addr;
    end
    if (resp_valid_d) begin
      resp_q.data <= resp_data_d;
    end
  end

  assign ld_resp_valid_o = resp_valid_q;
  assign ld_resp_o       = resp_q;

  a_ack_wb_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_ack_o |-> wb_empty_i);

  a_mem_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule

`default_nettype wire

// File: wtc_dcache.sv
/*
 * write-through L1 data cache top level joining the missunit, arrays,
 * store buffer and flush counter
 */
`timescale 1ns/1ps
`default_nettype none

module wtc_dcache #(
  parameter int WbufDepth = 4
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // cache management
  input  logic               enable_i,
  input  logic               flush_i,
  output logic               flush_ack_o,
  output logic               miss_o,
  output logic               wbuffer_empty_o,
  // load port
  input  logic               ld_req_valid_i,
  input  wtc_pkg::ld_req_t   ld_req_i,
  output logic               ld_req_ready_o,
  output logic               ld_resp_valid_o,
  output wtc_pkg::ld_resp_t  ld_resp_o,
  // store port
  input  logic               st_req_valid_i,
  input  wtc_pkg::st_req_t   st_req_i,
  output logic               st_req_ready_o,
  // memory port
  output logic               mem_req_valid_o,
  input  logic               mem_req_ready_i,
  output wtc_pkg::mem_req_t  mem_req_o,
  input  logic               mem_rtrn_valid_i,
  input  wtc_pkg::mem_rtrn_t mem_rtrn_i
);

  // missunit <-> arrays
  logic                       lookup_valid, hit;
  logic [wtc_pkg::ADDR_W-1:0] lookup_addr, refill_addr;
  logic [wtc_pkg::WORD_W-1:0] rdata;
  logic                       refill_we, st_we, inval_we;
  wtc_pkg::mem_rtrn_t         refill_line;
  wtc_pkg::st_req_t           st_hit_req;
  logic [wtc_pkg::IDX_W-1:0]  inval_idx;

  // missunit <-> write buffer and counter
  logic                       wb_head_valid, wb_pop, wb_hazard;
  wtc_pkg::st_req_t           wb_head;
  logic [wtc_pkg::ADDR_W-1:0] wb_chk_addr;
  logic                       cnt_start, cnt_step, cnt_last;
  logic [wtc_pkg::IDX_W-1:0]  cnt_idx;

  wtc_missunit i_wtc_missunit (
    .clk_i, .arst_n_i, .enable_i, .flush_i, .flush_ack_o, .miss_o,
    .ld_req_valid_i, .ld_req_i, .ld_req_ready_o, .ld_resp_valid_o, .ld_resp_o,
    .mem_req_valid_o, .mem_req_ready_i, .mem_req_o, .mem_rtrn_valid_i, .mem_rtrn_i,
    .lookup_valid_o  ( lookup_valid    ),
    .lookup_addr_o   ( lookup_addr     ),
    .hit_i           ( hit             ),
    .rdata_i         ( rdata           ),
    .refill_we_o     ( refill_we       ),
    .refill_addr_o   ( refill_addr     ),
    .refill_line_o   ( refill_line     ),
    .st_we_o         ( st_we           ),
    .st_req_o        ( st_hit_req      ),
    .inval_we_o      ( inval_we        ),
    .inval_idx_o     ( inval_idx       ),
    .wb_head_valid_i ( wb_head_valid   ),
    .wb_head_i       ( wb_head         ),
    .wb_pop_o        ( wb_pop          ),
    .wb_chk_addr_o   ( wb_chk_addr     ),
    .wb_hazard_i     ( wb_hazard       ),
    .wb_empty_i      ( wbuffer_empty_o ),
    .cnt_start_o     ( cnt_start       ),
    .cnt_step_o      ( cnt_step        ),
    .cnt_idx_i       ( cnt_idx         ),
    .cnt_last_i      ( cnt_last        )
  );

  wtc_mem i_wtc_mem (
    .clk_i, .arst_n_i,
    .lookup_valid_i ( lookup_valid ),
    .lookup_addr_i  ( lookup_addr  ),
    .hit_o          ( hit          ),
    .rdata_o        ( rdata        ),
    .refill_we_i    ( refill_we    ),
    .refill_addr_i  ( refill_addr  ),
    .refill_line_i  ( refill_line  ),
    .st_we_i        ( st_we        ),
    .st_req_i       ( st_hit_req   ),
    .inval_we_i     ( inval_we     ),
    .inval_idx_i    ( inval_idx    )
  );

  // stores are refused for the whole flush
  wtc_wbuffer #(
    .WbufDepth ( WbufDepth )
  ) i_wtc_wbuffer (
    .clk_i, .arst_n_i,
    .st_valid_i   ( st_req_valid_i  ),
    .st_req_i     ( st_req_i        ),
    .st_ready_o   ( st_req_ready_o  ),
    .flush_busy_i ( flush_i         ),
    .head_valid_o ( wb_head_valid   ),
    .head_o       ( wb_head         ),
    .pop_i        ( wb_pop          ),
    .chk_addr_i   ( wb_chk_addr     ),
    .hazard_o     ( wb_hazard       ),
    .empty_o      ( wbuffer_empty_o )
  );

  wtc_flush_cnt i_wtc_flush_cnt (
    .clk_i, .arst_n_i,
    .cnt_start_i ( cnt_start ),
    .cnt_step_i  ( cnt_step  ),
    .cnt_idx_o   ( cnt_idx   ),
    .cnt_last_o  ( cnt_last  )
  );

endmodule

`default_nettype wire

// File: wtc_dcache_tb.sv
/*
 * write-through data cache testbench with clock, reset, memory model,
 * reference memory, line residency model, directed and random stimulus
 */
`timescale 1ns/1ps
`default_nettype none

module wtc_dcache_tb;

  localparam int MemWords  = 1 << (wtc_pkg::ADDR_W - 2);
  localparam int WaitLimit = 400;
  // same set with different tags
  localparam logic [wtc_pkg::ADDR_W-1:0] AddrA = 16'h0040;
  localparam logic [wtc_pkg::ADDR_W-1:0] AddrB = 16'h0144;

  logic               clk_i, arst_n_i, enable_i, flush_i;
  logic               flush_ack_o, miss_o, wbuffer_empty_o;
  logic               ld_req_valid_i, ld_req_ready_o, ld_resp_valid_o;
  wtc_pkg::ld_req_t   ld_req_i;
  wtc_pkg::ld_resp_t  ld_resp_o;
  logic               st_req_valid_i, st_req_ready_o;
  wtc_pkg::st_req_t   st_req_i;
  logic               mem_req_valid_o, mem_req_ready_i, mem_rtrn_valid_i;
  wtc_pkg::mem_req_t  mem_req_o;
  wtc_pkg::mem_rtrn_t mem_rtrn_i;

  logic [wtc_pkg::WORD_W-1:0] mem_q [MemWords];
  logic [wtc_pkg::WORD_W-1:0] ref_q [MemWords];
  // lines the cache is expected to hold, one per set
  logic [wtc_pkg::NUM_SETS-1:0] cached_vld;
  logic [wtc_pkg::ADDR_W-1:4]   cached_line [wtc_pkg::NUM_SETS];
  wtc_pkg::st_req_t           store_order_q [$];
  wtc_pkg::st_req_t           oldest_st;
  logic [wtc_pkg::ADDR_W-1:0] rd_addr;
  int miss_cnt = 0;
  int read_cnt = 0;
  int rtrn_cnt = 0;
  int rtrn_wait = 0;
  int rd_delay = 0;

  wtc_dcache #(.WbufDepth(4)) i_wtc_dcache (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] fill_word(input int idx);
    return (32'(idx) * 32'h9e3779b1) ^ 32'h5a5a0000;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp)
      else report_failure($sformatf("Error %s: expected %0h, actual %0h", name, exp, act));
  endtask

  // starts and ends on a falling edge and checks data, misses and reads
  task automatic load_and_check(input logic [wtc_pkg::ADDR_W-1:0] addr, input string name,
                                output int lat);
    int n;
    int miss0;
    int read0;
    int set_idx;
    logic exp_miss;
    n        = 0;
    set_idx  = int'(addr[7:4]);
    // a disabled cache bypasses every load
    exp_miss = !enable_i || !cached_vld[set_idx] || (cached_line[set_idx] != addr[15:4]);
    ld_req_valid_i = 1'b1;
    ld_req_i.addr  = addr;
    while (!ld_req_ready_o) begin
      @(negedge clk_i);
      n++;
      if (n > WaitLimit) report_failure("timeout waiting for a load to be accepted");
    end
    miss0 = miss_cnt;
    read0 = read_cnt;
    @(negedge clk_i);
    ld_req_valid_i = 1'b0;
    lat = 0;
    while (!ld_resp_valid_o) begin
      @(negedge clk_i);
      lat++;
      if (lat > WaitLimit) report_failure("timeout waiting for a load response");
    end
    check_val(name, ref_q[addr[wtc_pkg::ADDR_W-1:2]], ld_resp_o.data);
    check_val({name, " miss count"}, exp_miss, miss_cnt - miss0);
    check_val({name, " read count"}, exp_miss, read_cnt - read0);
    // only enabled loads allocate
    if (enable_i) begin
      cached_vld[set_idx]  = 1'b1;
      cached_line[set_idx] = addr[15:4];
    end
  endtask

  task automatic store_word(input logic [wtc_pkg::ADDR_W-1:0] addr,
                            input logic [31:0] data, input logic [3:0] be);
    int n;
    n = 0;
    st_req_valid_i = 1'b1;
    st_req_i.addr  = addr;
    st_req_i.data  = data;
    st_req_i.be    = be;
    while (!st_req_ready_o) begin
      @(negedge clk_i);
      n++;
      if (n > WaitLimit) report_failure("timeout waiting for a store to be accepted");
    end
    @(negedge clk_i);
    st_req_valid_i = 1'b0;
  endtask

  task automatic flush_cache();
    int n;
    n = 0;
    flush_i = 1'b1;
    while (!flush_ack_o) begin
      @(negedge clk_i);
      n++;
      if (n > WaitLimit) report_failure("timeout waiting for the flush acknowledge");
    end
    assert (wbuffer_empty_o)
      else report_failure("write buffer not empty at the flush acknowledge");
    flush_i    = 1'b0;
    cached_vld = '0;
    @(negedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // memory model and monitors
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (arst_n_i) begin
      if (miss_o) miss_cnt++;
      if (mem_req_valid_o && mem_req_ready_i && mem_req_o.we) begin
        if (store_order_q.size() == 0) begin
          report_failure("memory write seen with no accepted store pending");
        end else begin
          // writes leave in the order the stores were accepted
          oldest_st = store_order_q.pop_front();
          check_val("write order", {oldest_st.addr, oldest_st.data, oldest_st.be},
                    {mem_req_o.addr, mem_req_o.wdata, mem_req_o.be});
          mem_q[mem_req_o.addr[15:2]] = merge_bytes(mem_q[mem_req_o.addr[15:2]],
                                                    mem_req_o.wdata, mem_req_o.be);
        end
      end else if (mem_req_valid_o && mem_req_ready_i) begin
        rd_addr  = mem_req_o.addr;
        rd_delay = $urandom % 5;
        read_cnt++;
      end
      if (st_req_valid_i && st_req_ready_o) begin
        store_order_q.push_back(st_req_i);
        ref_q[st_req_i.addr[15:2]] = merge_bytes(ref_q[st_req_i.addr[15:2]],
                                                 st_req_i.data, st_req_i.be);
      end
    end
  end

  // random ready and a line return after a random delay
  initial begin
    mem_req_ready_i  = 1'b0;
    mem_rtrn_valid_i = 1'b0;
    mem_rtrn_i       = '0;
    forever begin
      @(negedge clk_i);
      mem_req_ready_i  = arst_n_i && (($urandom % 4) != 0);
      mem_rtrn_valid_i = 1'b0;
      if (read_cnt != rtrn_cnt) begin
        if (rtrn_wait >= rd_delay) begin
          for (int w = 0; w < wtc_pkg::WORDS_PER_LINE; w++) begin
            mem_rtrn_i.data[w] = mem_q[int'(rd_addr[15:2]) + w];
          end
          mem_rtrn_valid_i = 1'b1;
          rtrn_cnt++;
          rtrn_wait = 0;
        end else begin
          rtrn_wait++;
        end
      end
    end
  end

  a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (mem_req_valid_o && !mem_req_ready_i) |=> (mem_req_valid_o && $stable(mem_req_o)))
    else report_failure("memory request changed while held by back-pressure");

  a_reset_idle: assert property (@(posedge clk_i)
      (!arst_n_i || $rose(arst_n_i)) |->
      (!ld_resp_valid_o && !mem_req_valid_o && !flush_ack_o && !miss_o && wbuffer_empty_o))
    else report_failure("outputs not idle during or right after reset");

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [wtc_pkg::ADDR_W-1:0] addr;
    int lat, op, n;
    void'($urandom(32'hc9e9613f));
    arst_n_i       = 1'b1;
    enable_i       = 1'b1;
    flush_i        = 1'b0;
    ld_req_valid_i = 1'b0;
    ld_req_i       = '0;
    st_req_valid_i = 1'b0;
    st_req_i       = '0;
    cached_vld     = '0;
    for (int i = 0; i < MemWords; i++) begin
      mem_q[i] = fill_word(i);
      ref_q[i] = fill_word(i);
    end
    #1 arst_n_i = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_val("ready after reset", 1, ld_req_ready_o);

    // miss then hit on the same line
    load_and_check(AddrA, "first load", lat);
    load_and_check(AddrA, "hit load", lat);
    check_val("hit latency", 1, lat);
    load_and_check(AddrA + 4, "hit load same line", lat);
    check_val("same line hit latency", 1, lat);

    // store hit and load hazard, then a conflicting line
    store_word(AddrA, $urandom, 4'hf);
    load_and_check(AddrA, "load after store hit", lat);
    store_word(AddrA + 8, $urandom, 4'b0101);
    load_and_check(AddrA + 8, "load after partial store", lat);
    store_word(AddrB, $urandom, 4'b1100);
    load_and_check(AddrB, "load after store miss", lat);
    load_and_check(AddrA, "reload evicted line", lat);

    // flush with stores pending and a miss on the line cached before it
    store_word(AddrA + 12, $urandom, 4'hf);
    store_word(AddrB + 4, $urandom, 4'b0011);
    flush_cache();
    load_and_check(AddrA, "load after flush", lat);

    // bypass, repeated to one address
    enable_i = 1'b0;
    for (int i = 0; i < 2; i++) begin
      load_and_check(AddrA, "bypass load", lat);
    end
    enable_i = 1'b1;

    for (int i = 0; i < 400; i++) begin
      addr = {6'b0, 8'($urandom), 2'b00};
      op   = $urandom % 16;
      if (op == 0) begin
        flush_cache();
      end else if (op == 1) begin
        enable_i = !enable_i;
      end else if (op < 8) begin
        store_word(addr, $urandom, 4'($urandom_range(15, 1)));
      end else begin
        load_and_check(addr, "random load", lat);
      end
    end

    n = 0;
    while (!wbuffer_empty_o) begin
      @(negedge clk_i);
      n++;
      if (n > WaitLimit) report_failure("timeout waiting for the final store drain");
    end
    for (int w = 0; w < 256; w++) begin
      check_val("memory contents", ref_q[w], mem_q[w]);
    end
    if (store_order_q.size() == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      report_failure("accepted stores never reached memory");
    end
  end

endmodule

`default_nettype wire

// File: wtc_dcache.f
wtc_pkg.sv
wtc_flush_cnt.sv
wtc_mem.sv
wtc_wbuffer.sv
wtc_missunit.sv
wtc_dcache.sv
wtc_dcache_tb.sv

// File: Makefile
# Verilator build and run of the write-through data cache testbench

VERILATOR ?= verilator
TOP       ?= wtc_dcache_tb
FLIST     ?= wtc_dcache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= ** FAIL **
PASS_MSG  ?= ** PASS **

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(SIM_BIN): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
